// ==== rtl/issue_defines.svh ====
/*
 * widths and counts for the issue and operand-read stage
 */
`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// data path width
`define XLEN 64

// architectural register addressing
`define REG_ADDR_BITS 5
`define NR_REGS 32

// write ports from the commit stage
`define NR_COMMIT_PORTS 2

// scoreboard tag
`define TRANS_ID_BITS 3

// operator code handed to the units
`define OP_BITS 8

`endif

// ==== rtl/issue_pkg.sv ====
/*
 * issue stage types: functional unit enum, scoreboard entry,
 * unit payload, commit write port, clobber table and operand request
 */
`include "issue_defines.svh"

package issue_pkg;

    // unit an entry needs, NONE for entries that only retire
    typedef enum logic [2:0] {
        NONE      = 3'd0,
        ALU       = 3'd1,
        CTRL_FLOW = 3'd2,
        MULT      = 3'd3,
        CSR       = 3'd4,
        LOAD      = 3'd5,
        STORE     = 3'd6
    } fu_t;

    typedef struct packed {
        logic [`XLEN-1:0]          pc;
        logic [`TRANS_ID_BITS-1:0] trans_id;
        fu_t                       fu;
        logic [`OP_BITS-1:0]       op;
        logic [`REG_ADDR_BITS-1:0] rs1;
        logic [`REG_ADDR_BITS-1:0] rs2;
        logic [`REG_ADDR_BITS-1:0] rd;
        logic [`XLEN-1:0]          result;    // immediate until the entry executes
        logic                      use_imm;
        logic                      use_zimm;
        logic                      use_pc;
        logic                      ex_valid;
    } sb_entry_t;

    typedef struct packed {
        fu_t                       fu;
        logic [`OP_BITS-1:0]       op;
        logic [`XLEN-1:0]          operand_a;
        logic [`XLEN-1:0]          operand_b;
        logic [`XLEN-1:0]          imm;
        logic [`TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    // which unit will write each register
    typedef fu_t [`NR_REGS-1:0] clobber_table_t;

    typedef struct packed {
        logic [`REG_ADDR_BITS-1:0] waddr;
        logic [`XLEN-1:0]          wdata;
        logic                      we;
    } commit_port_t;

    // the part of an entry the operand mux looks at
    typedef struct packed {
        logic [`REG_ADDR_BITS-1:0] rs1;
        logic [`XLEN-1:0]          pc;
        logic [`XLEN-1:0]          result;
        logic                      use_imm;
        logic                      use_zimm;
        logic                      use_pc;
    } operand_req_t;

endpackage

// ==== rtl/int_regfile.sv ====
/*
 * integer register file, x0 hard-wired to zero
 * two combinational read ports, one write port per commit port
 */
`include "issue_defines.svh"

module int_regfile import issue_pkg::*; #(
    parameter int unsigned NR_WRITE_PORTS = `NR_COMMIT_PORTS
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic [1:0][`REG_ADDR_BITS-1:0]      raddr_i,
    input  commit_port_t [NR_WRITE_PORTS-1:0]   commit_i,
    output logic [1:0][`XLEN-1:0]               rdata_o
);

    logic [`NR_REGS-1:0][`XLEN-1:0] regs_q;

    // ------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------
    // ports are walked in order so the highest port wins on a clash
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            regs_q <= '0;
        end else begin
            for (int unsigned p = 0; p < NR_WRITE_PORTS; p++) begin
                if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
                    regs_q[commit_i[p].waddr] <= commit_i[p].wdata;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------
    for (genvar r = 0; r < 2; r++) begin : gen_read
        // x0 never holds anything but zero
        assign rdata_o[r] = (raddr_i[r] == '0) ? '0 : regs_q[raddr_i[r]];
    end

endmodule

// ==== rtl/hazard_check.sv ====
/*
 * input side of the issue stage: clobber lookup, forwarding decision,
 * stall, unit busy and WAW checks, issue acknowledge
 */
`include "issue_defines.svh"

module hazard_check import issue_pkg::*; (
    input  sb_entry_t                           issue_instr_i,
    input  logic                                issue_valid_i,
    input  logic                                rs1_valid_i,
    input  logic                                rs2_valid_i,
    input  clobber_table_t                      rd_clobber_i,
    input  commit_port_t [`NR_COMMIT_PORTS-1:0] commit_i,
    input  logic                                flu_ready_i,
    input  logic                                lsu_ready_i,
    input  logic                                mult_lock_i,
    output logic                                issue_ack_o,
    output logic                                issue_fire_o,
    output logic [`REG_ADDR_BITS-1:0]           rs1_o,
    output logic [`REG_ADDR_BITS-1:0]           rs2_o,
    output logic                                forward_rs1_o,
    output logic                                forward_rs2_o,
    output operand_req_t                        operand_req_o
);

    fu_t  clobber_rs1;
    fu_t  clobber_rs2;
    fu_t  clobber_rd;
    logic stall;
    logic fu_busy;
    logic rd_commit_hit;

    // scoreboard lookup addresses
    assign rs1_o = issue_instr_i.rs1;
    assign rs2_o = issue_instr_i.rs2;

    assign clobber_rs1 = rd_clobber_i[issue_instr_i.rs1];
    assign clobber_rs2 = rd_clobber_i[issue_instr_i.rs2];
    assign clobber_rd  = rd_clobber_i[issue_instr_i.rd];

    // ------------------------------------------------------------------
    // operand availability
    // ------------------------------------------------------------------
    // CSR results only reach the register file, so they never forward
    always_comb begin
        stall         = 1'b0;
        forward_rs1_o = 1'b0;
        forward_rs2_o = 1'b0;
        // zimm sits in the rs1 field and needs no register
        if (!issue_instr_i.use_zimm && (clobber_rs1 != NONE)) begin
            if (rs1_valid_i && (clobber_rs1 != CSR)) begin
                forward_rs1_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
        if (clobber_rs2 != NONE) begin
            if (rs2_valid_i && (clobber_rs2 != CSR)) begin
                forward_rs2_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
    end

    // unit readiness
    always_comb begin
        unique case (issue_instr_i.fu)
            ALU, CTRL_FLOW, MULT, CSR: fu_busy = ~flu_ready_i;
            LOAD, STORE:               fu_busy = ~lsu_ready_i;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // a commit writing rd this cycle clears the WAW hazard
    always_comb begin
        rd_commit_hit = 1'b0;
        for (int unsigned p = 0; p < `NR_COMMIT_PORTS; p++) begin
            if (commit_i[p].we && (commit_i[p].waddr == issue_instr_i.rd)) begin
                rd_commit_hit = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // acknowledge
    // ------------------------------------------------------------------
    always_comb begin
        issue_ack_o = 1'b0;
        if (issue_valid_i) begin
            if (issue_instr_i.ex_valid && !fu_busy) begin
                issue_ack_o = 1'b1;
            end
            if (issue_instr_i.fu == NONE) begin
                issue_ack_o = 1'b1;
            end
            if (!stall && !fu_busy && ((clobber_rd == NONE) || rd_commit_hit)) begin
                issue_ack_o = 1'b1;
            end
        end
        // the multiplier shares the fixed-latency result bus
        if (mult_lock_i && (issue_instr_i.fu != MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

    assign issue_fire_o = issue_ack_o && !issue_instr_i.ex_valid && (issue_instr_i.fu != NONE);

    assign operand_req_o = '{
        rs1:      issue_instr_i.rs1,
        pc:       issue_instr_i.pc,
        result:   issue_instr_i.result,
        use_imm:  issue_instr_i.use_imm,
        use_zimm: issue_instr_i.use_zimm,
        use_pc:   issue_instr_i.use_pc
    };

    always_comb begin
        ack_valid_a: assert final (!issue_ack_o || issue_valid_i)
            else $error("issue ack raised without a valid entry");
    end

endmodule

// ==== rtl/operand_select.sv ====
/*
 * operand mux: register file, forwarded value, pc, zimm or immediate
 * assembled into the unit payload
 */
`include "issue_defines.svh"

module operand_select import issue_pkg::*; (
    input  operand_req_t               operand_req_i,
    input  logic                       forward_rs1_i,
    input  logic                       forward_rs2_i,
    input  logic [`XLEN-1:0]           rs1_i,
    input  logic [`XLEN-1:0]           rs2_i,
    input  logic [1:0][`XLEN-1:0]      rdata_i,
    input  fu_t                        fu_i,
    input  logic [`OP_BITS-1:0]        op_i,
    input  logic [`TRANS_ID_BITS-1:0]  trans_id_i,
    output fu_data_t                   fu_data_o
);

    logic [`XLEN-1:0] operand_a;
    logic [`XLEN-1:0] operand_b;

    // ------------------------------------------------------------------
    // operand a
    // ------------------------------------------------------------------
    always_comb begin
        operand_a = forward_rs1_i ? rs1_i : rdata_i[0];
        if (operand_req_i.use_pc) begin
            operand_a = operand_req_i.pc;
        end
        // zimm wins over pc, zero extended from the rs1 field
        if (operand_req_i.use_zimm) begin
            operand_a = {{(`XLEN-`REG_ADDR_BITS){1'b0}}, operand_req_i.rs1};
        end
    end

    // ------------------------------------------------------------------
    // operand b
    // ------------------------------------------------------------------
    // stores keep rs2 as data and branches compare rs2, both take the
    // immediate through imm instead
    always_comb begin
        operand_b = forward_rs2_i ? rs2_i : rdata_i[1];
        if (operand_req_i.use_imm && (fu_i != STORE) && (fu_i != CTRL_FLOW)) begin
            operand_b = operand_req_i.result;
        end
    end

    assign fu_data_o = '{
        fu:        fu_i,
        op:        op_i,
        operand_a: operand_a,
        operand_b: operand_b,
        imm:       operand_req_i.result,
        trans_id:  trans_id_i
    };

endmodule

// ==== rtl/fu_dispatch.sv ====
/*
 * output register of the issue stage: unit payload, per-unit valids,
 * branch pc, flush and the multiply lock
 */
`include "issue_defines.svh"

module fu_dispatch import issue_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              issue_fire_i,
    input  fu_t               fu_i,
    input  logic [`XLEN-1:0]  pc_i,
    input  fu_data_t          fu_data_i,
    output fu_data_t          fu_data_o,
    output logic              alu_valid_o,
    output logic              branch_valid_o,
    output logic              lsu_valid_o,
    output logic              mult_valid_o,
    output logic              csr_valid_o,
    output logic [`XLEN-1:0]  pc_o,
    output logic              mult_lock_o
);

    // bit positions in the valid vector
    localparam int unsigned V_ALU    = 0;
    localparam int unsigned V_BRANCH = 1;
    localparam int unsigned V_LSU    = 2;
    localparam int unsigned V_MULT   = 3;
    localparam int unsigned V_CSR    = 4;

    logic [4:0]       valid_d;
    logic [4:0]       valid_q;
    fu_data_t         fu_data_q;
    logic [`XLEN-1:0] pc_q;

    // ------------------------------------------------------------------
    // unit decode
    // ------------------------------------------------------------------
    // a flush drops whatever fires in the same cycle
    always_comb begin
        valid_d = '0;
        if (issue_fire_i && !flush_i) begin
            unique case (fu_i)
                ALU:         valid_d[V_ALU]    = 1'b1;
                CTRL_FLOW:   valid_d[V_BRANCH] = 1'b1;
                LOAD, STORE: valid_d[V_LSU]    = 1'b1;
                MULT:        valid_d[V_MULT]   = 1'b1;
                CSR:         valid_d[V_CSR]    = 1'b1;
                default:     valid_d           = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q   <= '0;
            fu_data_q <= '0;
        end else begin
            valid_q   <= valid_d;
            fu_data_q <= fu_data_i;
        end
    end

    // branch pc only moves when a branch goes out
    always_ff @(posedge clk_i) begin
        if (issue_fire_i && (fu_i == CTRL_FLOW)) begin
            pc_q <= pc_i;
        end
    end

    assign fu_data_o      = fu_data_q;
    assign alu_valid_o    = valid_q[V_ALU];
    assign branch_valid_o = valid_q[V_BRANCH];
    assign lsu_valid_o    = valid_q[V_LSU];
    assign mult_valid_o   = valid_q[V_MULT];
    assign csr_valid_o    = valid_q[V_CSR];
    assign mult_lock_o    = valid_q[V_MULT];
    assign pc_o           = pc_q;

    valid_onehot_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni) $onehot0(valid_q)
    ) else $error("more than one unit valid at once");

endmodule

// ==== rtl/issue_read_operands.sv ====
/*
 * issue and operand-read stage top level
 * hazard check, register file, operand mux and output register
 */
`include "issue_defines.svh"

module issue_read_operands import issue_pkg::*; (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                flush_i,
    input  sb_entry_t                           issue_instr_i,
    input  logic                                issue_valid_i,
    output logic                                issue_ack_o,
    output logic [`REG_ADDR_BITS-1:0]           rs1_o,
    input  logic [`XLEN-1:0]                    rs1_i,
    input  logic                                rs1_valid_i,
    output logic [`REG_ADDR_BITS-1:0]           rs2_o,
    input  logic [`XLEN-1:0]                    rs2_i,
    input  logic                                rs2_valid_i,
    input  clobber_table_t                      rd_clobber_i,
    input  commit_port_t [`NR_COMMIT_PORTS-1:0] commit_i,
    input  logic                                flu_ready_i,
    input  logic                                lsu_ready_i,
    output fu_data_t                            fu_data_o,
    output logic                                alu_valid_o,
    output logic                                branch_valid_o,
    output logic                                lsu_valid_o,
    output logic                                mult_valid_o,
    output logic                                csr_valid_o,
    output logic [`XLEN-1:0]                    pc_o
);

    logic                    issue_fire;
    logic                    forward_rs1;
    logic                    forward_rs2;
    logic                    mult_lock;
    operand_req_t            operand_req;
    logic [1:0][`XLEN-1:0]   rdata;
    fu_data_t                fu_data_n;

    hazard_check hazard_check_inst (
        .issue_instr_i (issue_instr_i),
        .issue_valid_i (issue_valid_i),
        .rs1_valid_i   (rs1_valid_i),
        .rs2_valid_i   (rs2_valid_i),
        .rd_clobber_i  (rd_clobber_i),
        .commit_i      (commit_i),
        .flu_ready_i   (flu_ready_i),
        .lsu_ready_i   (lsu_ready_i),
        .mult_lock_i   (mult_lock),
        .issue_ack_o   (issue_ack_o),
        .issue_fire_o  (issue_fire),
        .rs1_o         (rs1_o),
        .rs2_o         (rs2_o),
        .forward_rs1_o (forward_rs1),
        .forward_rs2_o (forward_rs2),
        .operand_req_o (operand_req)
    );

    // read port 0 serves rs1, port 1 serves rs2
    int_regfile #(
        .NR_WRITE_PORTS (`NR_COMMIT_PORTS)
    ) int_regfile_inst (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .raddr_i  ({rs2_o, rs1_o}),
        .commit_i (commit_i),
        .rdata_o  (rdata)
    );

    operand_select operand_select_inst (
        .operand_req_i (operand_req),
        .forward_rs1_i (forward_rs1),
        .forward_rs2_i (forward_rs2),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .rdata_i       (rdata),
        .fu_i          (issue_instr_i.fu),
        .op_i          (issue_instr_i.op),
        .trans_id_i    (issue_instr_i.trans_id),
        .fu_data_o     (fu_data_n)
    );

    fu_dispatch fu_dispatch_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .issue_fire_i   (issue_fire),
        .fu_i           (issue_instr_i.fu),
        .pc_i           (issue_instr_i.pc),
        .fu_data_i      (fu_data_n),
        .fu_data_o      (fu_data_o),
        .alu_valid_o    (alu_valid_o),
        .branch_valid_o (branch_valid_o),
        .lsu_valid_o    (lsu_valid_o),
        .mult_valid_o   (mult_valid_o),
        .csr_valid_o    (csr_valid_o),
        .pc_o           (pc_o),
        .mult_lock_o    (mult_lock)
    );

endmodule

// ==== tests/tb_issue_read_operands.sv ====
/*
 * testbench for the issue and operand-read stage: clock and reset,
 * LFSR stimulus, register model, assertions and the error count
 */
`include "issue_defines.svh"

module tb_issue_read_operands import issue_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [4:0] V_NONE = 5'b00000;
    localparam logic [4:0] V_ALU  = 5'b10000;
    localparam logic [4:0] V_BR   = 5'b01000;
    localparam logic [4:0] V_LSU  = 5'b00100;
    localparam logic [4:0] V_MULT = 5'b00010;
    localparam logic [4:0] V_CSR  = 5'b00001;

    logic clk_i;
    logic rst_ni;
    logic flush_i;
    sb_entry_t issue_instr_i;
    logic issue_valid_i;
    logic issue_ack_o;
    logic [`REG_ADDR_BITS-1:0] rs1_o;
    logic [`REG_ADDR_BITS-1:0] rs2_o;
    logic [`XLEN-1:0] rs1_i;
    logic [`XLEN-1:0] rs2_i;
    logic rs1_valid_i;
    logic rs2_valid_i;
    clobber_table_t rd_clobber_i;
    commit_port_t [`NR_COMMIT_PORTS-1:0] commit_i;
    logic flu_ready_i;
    logic lsu_ready_i;
    fu_data_t fu_data_o;
    logic alu_valid_o;
    logic branch_valid_o;
    logic lsu_valid_o;
    logic mult_valid_o;
    logic csr_valid_o;
    logic [`XLEN-1:0] pc_o;

    logic [15:0] lfsr_q = 16'd11881;
    logic [`TRANS_ID_BITS-1:0] next_id = '0;
    logic [`XLEN-1:0] reg_model [`NR_REGS];
    int unsigned checks = 0;
    int unsigned mismatch_count = 0;
    int unsigned timeout_count = 0;

    issue_read_operands issue_read_operands_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------
    // protocol properties
    // ------------------------------------------------------------------
    alu_follows_ack_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (issue_valid_i && issue_ack_o && !flush_i && !issue_instr_i.ex_valid
            && (issue_instr_i.fu == ALU)) |=> alu_valid_o
    ) else begin
        mismatch_count++;
        $display("mismatch at %0t: ALU entry acknowledged but alu_valid_o stayed low", $time);
    end

    exception_silent_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (issue_valid_i && issue_ack_o && issue_instr_i.ex_valid)
            |=> !(alu_valid_o || branch_valid_o || lsu_valid_o || mult_valid_o || csr_valid_o)
    ) else begin
        mismatch_count++;
        $display("mismatch at %0t: exception entry raised a unit valid", $time);
    end

    // fibonacci LFSR, taps 16 14 13 11, one step per bit taken
    function automatic logic [63:0] rand_bits(input int unsigned n);
        logic [63:0] v;
        logic fb;
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            v = {v[62:0], lfsr_q[15]};
            lfsr_q = {lfsr_q[14:0], fb};
        end
        return v;
    endfunction

    function automatic sb_entry_t new_entry(input fu_t fu, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input logic [4:0] rd);
        sb_entry_t e;
        logic [63:0] r;
        e = '0;
        r = rand_bits(62);
        e.pc = {r[61:0], 2'b00};
        e.trans_id = next_id;
        next_id = next_id + 1'b1;
        e.fu = fu;
        r = rand_bits(`OP_BITS);
        e.op = r[`OP_BITS-1:0];
        e.rs1 = rs1;
        e.rs2 = rs2;
        e.rd = rd;
        e.result = rand_bits(64);
        return e;
    endfunction

    task automatic check_word(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            mismatch_count++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_valids(input logic [4:0] exp);
        check_word("unit valids",
                   64'({alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o}),
                   64'(exp));
    endtask

    task automatic check_payload(input sb_entry_t e, input logic [63:0] a, input logic [63:0] b);
        check_word("fu", 64'(fu_data_o.fu), 64'(e.fu));
        check_word("op", 64'(fu_data_o.op), 64'(e.op));
        check_word("operand_a", fu_data_o.operand_a, a);
        check_word("operand_b", fu_data_o.operand_b, b);
        check_word("imm", fu_data_o.imm, e.result);
        check_word("trans_id", 64'(fu_data_o.trans_id), 64'(e.trans_id));
    endtask

    // commits both ports for one cycle, port 1 lands last so it wins a clash
    task automatic commit_regs(input logic [4:0] a0, input logic [63:0] d0,
                               input logic [4:0] a1, input logic [63:0] d1);
        commit_i[0] = '{waddr: a0, wdata: d0, we: 1'b1};
        commit_i[1] = '{waddr: a1, wdata: d1, we: 1'b1};
        if (a0 != '0) reg_model[a0] = d0;
        if (a1 != '0) reg_model[a1] = d1;
        @(posedge clk_i);
        #2;
        commit_i = '0;
    endtask

    task automatic present(input sb_entry_t e);
        issue_instr_i = e;
        issue_valid_i = 1'b1;
    endtask

    // ack is sampled mid-cycle, the entry is consumed at the next edge
    task automatic wait_ack(input int unsigned limit, output int unsigned waited);
        bit done;
        done = 1'b0;
        waited = 0;
        while (!done && (waited < limit)) begin
            @(negedge clk_i);
            // scoreboard lookup addresses follow the presented entry
            check_word("rs1_o", 64'(rs1_o), 64'(issue_instr_i.rs1));
            check_word("rs2_o", 64'(rs2_o), 64'(issue_instr_i.rs2));
            if (issue_ack_o) done = 1'b1;
            @(posedge clk_i);
            #2;
            if (!done) waited++;
        end
        issue_valid_i = 1'b0;
        if (!done) begin
            timeout_count++;
            $display("timeout at %0t: entry not acknowledged within %0d cycles", $time, limit);
        end
    endtask

    task automatic issue_entry(input sb_entry_t e, output int unsigned waited);
        present(e);
        wait_ack(8, waited);
    endtask

    task automatic expect_no_ack(input int unsigned n);
        repeat (n) begin
            @(negedge clk_i);
            check_word("issue_ack_o while blocked", 64'(issue_ack_o), 64'd0);
            @(posedge clk_i);
            #2;
        end
    endtask

    initial begin
        sb_entry_t e;
        int unsigned w;
        for (int i = 0; i < `NR_REGS; i++) reg_model[i] = '0;
        rst_ni = 1'b0;
        flush_i = 1'b0;
        issue_instr_i = '0;
        issue_valid_i = 1'b0;
        rs1_i = '0;
        rs2_i = '0;
        rs1_valid_i = 1'b0;
        rs2_valid_i = 1'b0;
        rd_clobber_i = '0;
        commit_i = '0;
        flu_ready_i = 1'b1;
        lsu_ready_i = 1'b1;
        repeat (10) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        // reset state, then fill a few registers (x0 write and a port clash)
        check_valids(V_NONE);
        check_word("fu_data set bits", 64'($countones(fu_data_o)), 64'd0);
        @(posedge clk_i);
        #2;
        commit_regs(5'd1, rand_bits(64), 5'd2, rand_bits(64));
        commit_regs(5'd0, rand_bits(64), 5'd3, rand_bits(64));
        commit_regs(5'd4, rand_bits(64), 5'd4, rand_bits(64));

        // plain ALU entry, x0 as rs2
        e = new_entry(ALU, 5'd1, 5'd0, 5'd6);
        issue_entry(e, w);
        check_word("ack delay", 64'(w), 64'd0);
        check_valids(V_ALU);
        check_payload(e, reg_model[1], reg_model[0]);
        @(posedge clk_i);
        #2;
        check_valids(V_NONE);

        // ------------------------------------------------------------------
        // forwarding from the scoreboard
        // ------------------------------------------------------------------
        rd_clobber_i[1] = ALU;
        rs1_valid_i = 1'b1;
        rs1_i = rand_bits(64);
        e = new_entry(ALU, 5'd1, 5'd2, 5'd7);
        issue_entry(e, w);
        check_word("ack delay", 64'(w), 64'd0);
        check_payload(e, rs1_i, reg_model[2]);
        rs1_valid_i = 1'b0;
        e = new_entry(ALU, 5'd1, 5'd2, 5'd7);
        present(e);
        expect_no_ack(2);
        rd_clobber_i[1] = CSR;
        rs1_valid_i = 1'b1;
        expect_no_ack(2);
        rd_clobber_i[1] = NONE;
        wait_ack(8, w);
        check_payload(e, reg_model[1], reg_model[2]);

        // operand sources: pc, zimm (its clobber is ignored), immediate
        e = new_entry(ALU, 5'd3, 5'd4, 5'd9);
        e.use_pc = 1'b1;
        issue_entry(e, w);
        check_payload(e, e.pc, reg_model[4]);
        rd_clobber_i[5] = CSR;
        e = new_entry(CSR, 5'd5, 5'd0, 5'd9);
        e.use_zimm = 1'b1;
        issue_entry(e, w);
        check_word("ack delay", 64'(w), 64'd0);
        check_valids(V_CSR);
        check_payload(e, 64'd5, reg_model[0]);
        rd_clobber_i[5] = NONE;
        e = new_entry(ALU, 5'd1, 5'd2, 5'd10);
        e.use_imm = 1'b1;
        issue_entry(e, w);
        check_payload(e, reg_model[1], e.result);
        e = new_entry(STORE, 5'd1, 5'd2, 5'd0);
        e.use_imm = 1'b1;
        issue_entry(e, w);
        check_valids(V_LSU);
        check_payload(e, reg_model[1], reg_model[2]);
        e = new_entry(CTRL_FLOW, 5'd3, 5'd4, 5'd0);
        e.use_imm = 1'b1;
        issue_entry(e, w);
        check_valids(V_BR);
        check_payload(e, reg_model[3], reg_model[4]);
        check_word("pc_o", pc_o, e.pc);

        // ------------------------------------------------------------------
        // write-after-write, released by a commit to rd
        // ------------------------------------------------------------------
        rd_clobber_i[11] = LOAD;
        e = new_entry(ALU, 5'd1, 5'd2, 5'd11);
        present(e);
        expect_no_ack(2);
        commit_i[1] = '{waddr: 5'd11, wdata: rand_bits(64), we: 1'b1};
        reg_model[11] = commit_i[1].wdata;
        wait_ack(8, w);
        commit_i = '0;
        rd_clobber_i[11] = NONE;
        check_word("ack delay", 64'(w), 64'd0);
        check_valids(V_ALU);
        e = new_entry(ALU, 5'd11, 5'd0, 5'd12);
        issue_entry(e, w);
        check_payload(e, reg_model[11], reg_model[0]);

        // back-pressure from the units
        flu_ready_i = 1'b0;
        e = new_entry(ALU, 5'd2, 5'd3, 5'd13);
        present(e);
        expect_no_ack(2);
        flu_ready_i = 1'b1;
        wait_ack(8, w);
        check_valids(V_ALU);
        lsu_ready_i = 1'b0;
        e = new_entry(LOAD, 5'd2, 5'd0, 5'd14);
        present(e);
        expect_no_ack(2);
        lsu_ready_i = 1'b1;
        wait_ack(8, w);
        check_valids(V_LSU);

        // flush, exception with a stalled rs1, and the no-unit entry
        flush_i = 1'b1;
        e = new_entry(ALU, 5'd1, 5'd2, 5'd15);
        issue_entry(e, w);
        flush_i = 1'b0;
        check_word("ack delay", 64'(w), 64'd0);
        check_valids(V_NONE);
        rd_clobber_i[3] = CSR;
        e = new_entry(ALU, 5'd3, 5'd0, 5'd15);
        e.ex_valid = 1'b1;
        issue_entry(e, w);
        rd_clobber_i[3] = NONE;
        check_word("ack delay", 64'(w), 64'd0);
        check_valids(V_NONE);
        e = new_entry(NONE, 5'd1, 5'd2, 5'd0);
        issue_entry(e, w);
        check_valids(V_NONE);

        // ------------------------------------------------------------------
        // multiply lock
        // ------------------------------------------------------------------
        e = new_entry(MULT, 5'd1, 5'd2, 5'd16);
        issue_entry(e, w);
        check_valids(V_MULT);
        e = new_entry(ALU, 5'd1, 5'd2, 5'd17);
        present(e);
        expect_no_ack(1);
        wait_ack(8, w);
        check_valids(V_ALU);
        e = new_entry(MULT, 5'd1, 5'd2, 5'd18);
        issue_entry(e, w);
        check_valids(V_MULT);
        e = new_entry(MULT, 5'd3, 5'd4, 5'd19);
        issue_entry(e, w);
        check_word("ack delay", 64'(w), 64'd0);
        check_valids(V_MULT);
        check_payload(e, reg_model[3], reg_model[4]);
        @(posedge clk_i);
        #2;

        $display("checks %0d, mismatches %0d, timeouts %0d",
                 checks, mismatch_count, timeout_count);
        if ((mismatch_count == 0) && (timeout_count == 0)) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/issue_pkg.sv
rtl/int_regfile.sv
rtl/hazard_check.sv
rtl/operand_select.sv
rtl/fu_dispatch.sv
rtl/issue_read_operands.sv
tests/tb_issue_read_operands.sv

// ==== Bender.yml ====
package:
  name: issue_read_operands

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/issue_pkg.sv
      - rtl/int_regfile.sv
      - rtl/hazard_check.sv
      - rtl/operand_select.sv
      - rtl/fu_dispatch.sv
      - rtl/issue_read_operands.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_issue_read_operands.sv
